// ==== logic/rsp_bank_consts.svh ====
`ifndef RSP_BANK_CONSTS_SVH
`define RSP_BANK_CONSTS_SVH

////////////////////////////////////////////////////////////
// Bank geometry
////////////////////////////////////////////////////////////

// Number of cells in the shared response RAM
`define RSP_BANK_CAPA 8
// Bits needed to address one cell
`define RSP_BANK_ADDR_W 3

// Number of AXI identifiers, one linked list each
`define RSP_BANK_NUM_IDS 4
// Bits of a binary AXI identifier
`define RSP_BANK_ID_W 2

// Response bits stored per cell, the ID travels beside it
`define RSP_BANK_PAYLOAD_W 16

`endif

// ==== logic/rsp_bank_pkg.sv ====
`include "rsp_bank_consts.svh"

package rsp_bank_pkg;

  ////////////////////////////////////////////////////////////
  // Vector types shared by the whole bank
  ////////////////////////////////////////////////////////////

  // Address of one RAM cell
  typedef logic [`RSP_BANK_ADDR_W-1:0] addr_t;

  // Binary AXI identifier
  typedef logic [`RSP_BANK_ID_W-1:0] id_t;

  // Response content without its identifier
  typedef logic [`RSP_BANK_PAYLOAD_W-1:0] payload_t;

  // List length, one bit wider than an address so that a full bank fits
  typedef logic [`RSP_BANK_ADDR_W:0] len_t;

  // One bit per cell, used for enables, occupancy and the release pulse
  typedef logic [`RSP_BANK_CAPA-1:0] cell_mask_t;

  // One bit per identifier
  typedef logic [`RSP_BANK_NUM_IDS-1:0] id_mask_t;

endpackage

// ==== logic/rsp_bank_pop_if.sv ====
`timescale 1ns/1ps

`include "rsp_bank_consts.svh"

// Status of the per-ID lists and the pop command that removes the oldest entry of one list
interface rsp_bank_pop_if;

  // Set for every ID whose list holds at least one stored response
  rsp_bank_pkg::id_mask_t avail;

  // Oldest cell of each list, only meaningful while the matching avail bit is set
  rsp_bank_pkg::addr_t tails [`RSP_BANK_NUM_IDS];

  // One-cycle command, there is no handshake back
  logic pop;
  rsp_bank_pkg::id_t pop_id;

  // The list manager publishes status and obeys pops
  modport lists (
    output avail,
    output tails,
    input  pop,
    input  pop_id
  );

  // The release side reads status and issues pops
  modport releaser (
    input  avail,
    input  tails,
    output pop,
    output pop_id
  );

endinterface

// ==== logic/rsp_bank_alloc.sv ====
`timescale 1ns/1ps

`include "rsp_bank_consts.svh"

module rsp_bank_alloc (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     i_rsv_valid,
  input  rsp_bank_pkg::cell_mask_t i_released,
  output logic                     o_rsv_ready,
  output rsp_bank_pkg::addr_t      o_rsv_addr,
  output logic                     o_rsv_fire
);

  // A bit is set from the cycle after its reservation until its release pulse
  rsp_bank_pkg::cell_mask_t occ_q;
  rsp_bank_pkg::cell_mask_t occ_d;

  rsp_bank_pkg::cell_mask_t free_cells;
  // One-hot copy of the lowest free cell, all zero when the bank is full
  rsp_bank_pkg::cell_mask_t lowest_free;
  rsp_bank_pkg::cell_mask_t grant;

  ////////////////////////////////////////////////////////////
  // Lowest free cell
  ////////////////////////////////////////////////////////////

  assign free_cells = ~occ_q;

  // Adding one to the inverted vector carries up to the first free bit only
  assign lowest_free = free_cells & (~free_cells + rsp_bank_pkg::cell_mask_t'(1));

  // Binary encoding of the one-hot search result
  always_comb begin
    o_rsv_addr = '0;
    for (int i = 0; i < `RSP_BANK_CAPA; i++) begin
      if (lowest_free[i]) begin
        o_rsv_addr = rsp_bank_pkg::addr_t'(i);
      end
    end
  end

  // Any free cell makes the bank ready, the grant itself is combinational
  assign o_rsv_ready = |free_cells;
  assign o_rsv_fire = i_rsv_valid && o_rsv_ready;

  ////////////////////////////////////////////////////////////
  // Occupancy update
  ////////////////////////////////////////////////////////////

  assign grant = o_rsv_fire ? lowest_free : '0;

  // A released cell was occupied this cycle, so it can never be the grant as well
  assign occ_d = (occ_q | grant) & ~i_released;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occ_q <= '0;
    end else begin
      occ_q <= occ_d;
    end
  end

endmodule

// ==== logic/rsp_bank_lists.sv ====
`timescale 1ns/1ps

`include "rsp_bank_consts.svh"

module rsp_bank_lists (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   i_rsv_fire,
  input  rsp_bank_pkg::addr_t    i_rsv_addr,
  input  rsp_bank_pkg::id_t      i_rsv_id,
  input  logic                   i_in_valid,
  input  rsp_bank_pkg::id_t      i_in_id,
  input  rsp_bank_pkg::payload_t i_in_payload,
  output logic                   o_in_ready,
  output logic                   o_wr_en,
  output rsp_bank_pkg::addr_t    o_wr_addr,
  output rsp_bank_pkg::payload_t o_wr_data,
  rsp_bank_pop_if.lists          pop
);

  // Per list, in linked order from oldest to newest:
  // tail is the oldest stored cell, or the oldest reserved one while nothing is stored
  // fill is the oldest reserved empty cell, or the head while none is left
  // head is the cell reserved last
  rsp_bank_pkg::addr_t rsv_head_q [`RSP_BANK_NUM_IDS];
  rsp_bank_pkg::addr_t rsv_head_d [`RSP_BANK_NUM_IDS];
  rsp_bank_pkg::addr_t fill_q [`RSP_BANK_NUM_IDS];
  rsp_bank_pkg::addr_t fill_d [`RSP_BANK_NUM_IDS];
  rsp_bank_pkg::addr_t tail_q [`RSP_BANK_NUM_IDS];
  rsp_bank_pkg::addr_t tail_d [`RSP_BANK_NUM_IDS];

  // Reserved cells still waiting for a response, and cells holding one
  rsp_bank_pkg::len_t rsv_len_q [`RSP_BANK_NUM_IDS];
  rsp_bank_pkg::len_t rsv_len_d [`RSP_BANK_NUM_IDS];
  rsp_bank_pkg::len_t rsp_len_q [`RSP_BANK_NUM_IDS];
  rsp_bank_pkg::len_t rsp_len_d [`RSP_BANK_NUM_IDS];

  // Next-cell links, read combinationally
  rsp_bank_pkg::addr_t next_q [`RSP_BANK_CAPA];

  rsp_bank_pkg::id_mask_t rsv_hit;
  rsp_bank_pkg::id_mask_t in_hit;
  rsp_bank_pkg::id_mask_t pop_hit;
  rsp_bank_pkg::id_mask_t occupied;

  logic in_fire;
  logic link_we;
  rsp_bank_pkg::addr_t link_src;

  ////////////////////////////////////////////////////////////
  // Events per identifier
  ////////////////////////////////////////////////////////////

  for (genvar g = 0; g < `RSP_BANK_NUM_IDS; g++) begin : gen_id
    assign rsv_hit[g] = i_rsv_fire && (i_rsv_id == rsp_bank_pkg::id_t'(g));
    assign in_hit[g] = in_fire && (i_in_id == rsp_bank_pkg::id_t'(g));
    assign pop_hit[g] = pop.pop && (pop.pop_id == rsp_bank_pkg::id_t'(g));
    // A list with no cell at all restarts from scratch on its next reservation
    assign occupied[g] = (rsv_len_q[g] != '0) || (rsp_len_q[g] != '0);
    assign pop.avail[g] = rsp_len_q[g] != '0;
    assign pop.tails[g] = tail_q[g];
  end

  // Ready depends on valid, which the AXI handshake rules allow
  assign o_in_ready = i_in_valid && (rsv_len_q[i_in_id] != '0);
  assign in_fire = o_in_ready;

  // The payload lands in the oldest empty reserved cell of its ID
  assign o_wr_en = in_fire;
  assign o_wr_addr = fill_q[i_in_id];
  assign o_wr_data = i_in_payload;

  // A reservation into a live list chains the new cell behind the current head
  assign link_we = i_rsv_fire && occupied[i_rsv_id];
  assign link_src = rsv_head_q[i_rsv_id];

  ////////////////////////////////////////////////////////////
  // Pointer and length update
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < `RSP_BANK_NUM_IDS; i++) begin
      rsv_head_d[i] = rsv_head_q[i];
      fill_d[i] = fill_q[i];
      tail_d[i] = tail_q[i];

      // All three events may hit the same list, so the counts simply add up
      rsv_len_d[i] = rsv_len_q[i] + rsp_bank_pkg::len_t'(rsv_hit[i])
                     - rsp_bank_pkg::len_t'(in_hit[i]);
      rsp_len_d[i] = rsp_len_q[i] + rsp_bank_pkg::len_t'(in_hit[i])
                     - rsp_bank_pkg::len_t'(pop_hit[i]);

      // With more than one empty cell the fill pointer is behind the head, so its link exists
      if (in_hit[i] && (rsv_len_q[i] > rsp_bank_pkg::len_t'(1))) begin
        fill_d[i] = next_q[fill_q[i]];
      end

      // The link out of the tail may be written in this very cycle, so forward it
      if (pop_hit[i]) begin
        if (link_we && (link_src == tail_q[i])) begin
          tail_d[i] = i_rsv_addr;
        end else begin
          tail_d[i] = next_q[tail_q[i]];
        end
      end

      if (rsv_hit[i]) begin
        rsv_head_d[i] = i_rsv_addr;
        if (!occupied[i]) begin
          fill_d[i] = i_rsv_addr;
          tail_d[i] = i_rsv_addr;
        end else if (rsv_len_q[i] == rsp_bank_pkg::len_t'(in_hit[i])) begin
          // No empty cell is left after this cycle's input, the new one is next to fill
          fill_d[i] = i_rsv_addr;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsv_head_q <= '{default: '0};
      fill_q <= '{default: '0};
      tail_q <= '{default: '0};
      rsv_len_q <= '{default: '0};
      rsp_len_q <= '{default: '0};
    end else begin
      rsv_head_q <= rsv_head_d;
      fill_q <= fill_d;
      tail_q <= tail_d;
      rsv_len_q <= rsv_len_d;
      rsp_len_q <= rsp_len_d;
    end
  end

  // Links of free cells are stale but never followed
  always_ff @(posedge clk_i) begin
    if (link_we) begin
      next_q[link_src] <= i_rsv_addr;
    end
  end

endmodule

// ==== logic/rsp_bank_payload_ram.sv ====
`timescale 1ns/1ps

`include "rsp_bank_consts.svh"

module rsp_bank_payload_ram (
  input  logic                   clk_i,
  input  logic                   i_wr_en,
  input  rsp_bank_pkg::addr_t    i_wr_addr,
  input  rsp_bank_pkg::payload_t i_wr_data,
  input  logic                   i_rd_en,
  input  rsp_bank_pkg::addr_t    i_rd_addr,
  output rsp_bank_pkg::payload_t o_rd_data
);

  rsp_bank_pkg::payload_t mem [`RSP_BANK_CAPA];

  // Read register, it keeps its value until the next read
  rsp_bank_pkg::payload_t rd_q;

  always_ff @(posedge clk_i) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_data;
    end
    // Reads target stored cells and writes target empty ones, so they never collide
    if (i_rd_en) begin
      rd_q <= mem[i_rd_addr];
    end
  end

  assign o_rd_data = rd_q;

endmodule

// ==== logic/rsp_bank_release.sv ====
`timescale 1ns/1ps

`include "rsp_bank_consts.svh"

module rsp_bank_release (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  rsp_bank_pkg::cell_mask_t i_release_en,
  input  logic                     i_out_ready,
  input  rsp_bank_pkg::payload_t   i_rd_data,
  output logic                     o_rd_en,
  output rsp_bank_pkg::addr_t      o_rd_addr,
  output logic                     o_out_valid,
  output rsp_bank_pkg::id_t        o_out_id,
  output rsp_bank_pkg::payload_t   o_out_payload,
  output rsp_bank_pkg::cell_mask_t o_released,
  rsp_bank_pop_if.releaser         pop
);

  // IDs whose oldest stored cell is enabled for release
  rsp_bank_pkg::id_mask_t qualify;
  rsp_bank_pkg::id_t win_id;

  logic out_fire;
  logic can_pop;
  logic pop_now;

  // Output register, the payload half of it is the RAM read register
  logic out_valid_q;
  rsp_bank_pkg::id_t out_id_q;
  rsp_bank_pkg::cell_mask_t out_cell_q;

  ////////////////////////////////////////////////////////////
  // Arbitration
  ////////////////////////////////////////////////////////////

  for (genvar g = 0; g < `RSP_BANK_NUM_IDS; g++) begin : gen_qualify
    assign qualify[g] = pop.avail[g] && i_release_en[pop.tails[g]];
  end

  // Scan downwards so that the lowest qualifying ID is written last and wins
  always_comb begin
    win_id = '0;
    for (int i = `RSP_BANK_NUM_IDS - 1; i >= 0; i--) begin
      if (qualify[i]) begin
        win_id = rsp_bank_pkg::id_t'(i);
      end
    end
  end

  assign out_fire = out_valid_q && i_out_ready;

  // A new read may start only if the output slot is empty or leaves in this cycle
  assign can_pop = !out_valid_q || i_out_ready;
  assign pop_now = can_pop && (|qualify);

  assign pop.pop = pop_now;
  assign pop.pop_id = win_id;

  assign o_rd_en = pop_now;
  assign o_rd_addr = pop.tails[win_id];

  ////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
    end else if (pop_now) begin
      out_valid_q <= 1'b1;
    end else if (out_fire) begin
      out_valid_q <= 1'b0;
    end
  end

  // ID and cell are captured together with the RAM read
  always_ff @(posedge clk_i) begin
    if (pop_now) begin
      out_id_q <= win_id;
      out_cell_q <= rsp_bank_pkg::cell_mask_t'(1) << o_rd_addr;
    end
  end

  assign o_out_valid = out_valid_q;
  assign o_out_id = out_id_q;
  assign o_out_payload = i_rd_data;

  // The cell of the leaving response is announced for exactly the handshake cycle
  assign o_released = out_fire ? out_cell_q : '0;

endmodule

// ==== logic/rsp_bank.sv ====
`timescale 1ns/1ps

module rsp_bank (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     i_rsv_valid,
  input  rsp_bank_pkg::id_t        i_rsv_id,
  input  rsp_bank_pkg::cell_mask_t i_release_en,
  input  logic                     i_in_valid,
  input  rsp_bank_pkg::id_t        i_in_id,
  input  rsp_bank_pkg::payload_t   i_in_payload,
  input  logic                     i_out_ready,
  output logic                     o_rsv_ready,
  output rsp_bank_pkg::addr_t      o_rsv_addr,
  output rsp_bank_pkg::cell_mask_t o_released_addr,
  output logic                     o_in_ready,
  output logic                     o_out_valid,
  output rsp_bank_pkg::id_t        o_out_id,
  output rsp_bank_pkg::payload_t   o_out_payload
);

  // Reservation grant towards the list manager
  logic rsv_fire;

  // Payload RAM ports
  logic wr_en;
  rsp_bank_pkg::addr_t wr_addr;
  rsp_bank_pkg::payload_t wr_data;
  logic rd_en;
  rsp_bank_pkg::addr_t rd_addr;
  rsp_bank_pkg::payload_t rd_data;

  // List status one way, pop commands the other
  rsp_bank_pop_if pop_bus ();

  rsp_bank_alloc u_alloc (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .i_rsv_valid (i_rsv_valid),
    .i_released  (o_released_addr),
    .o_rsv_ready (o_rsv_ready),
    .o_rsv_addr  (o_rsv_addr),
    .o_rsv_fire  (rsv_fire)
  );

  rsp_bank_lists u_lists (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .i_rsv_fire   (rsv_fire),
    .i_rsv_addr   (o_rsv_addr),
    .i_rsv_id     (i_rsv_id),
    .i_in_valid   (i_in_valid),
    .i_in_id      (i_in_id),
    .i_in_payload (i_in_payload),
    .o_in_ready   (o_in_ready),
    .o_wr_en      (wr_en),
    .o_wr_addr    (wr_addr),
    .o_wr_data    (wr_data),
    .pop          (pop_bus)
  );

  rsp_bank_payload_ram u_ram (
    .clk_i     (clk_i),
    .i_wr_en   (wr_en),
    .i_wr_addr (wr_addr),
    .i_wr_data (wr_data),
    .i_rd_en   (rd_en),
    .i_rd_addr (rd_addr),
    .o_rd_data (rd_data)
  );

  rsp_bank_release u_release (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .i_release_en  (i_release_en),
    .i_out_ready   (i_out_ready),
    .i_rd_data     (rd_data),
    .o_rd_en       (rd_en),
    .o_rd_addr     (rd_addr),
    .o_out_valid   (o_out_valid),
    .o_out_id      (o_out_id),
    .o_out_payload (o_out_payload),
    .o_released    (o_released_addr),
    .pop           (pop_bus)
  );

endmodule

// ==== bench/rsp_bank_chk.sv ====
`timescale 1ns/1ps

module rsp_bank_chk (
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     i_in_valid,
  input logic                     i_out_ready,
  input logic                     i_in_ready,
  input logic                     i_out_valid,
  input rsp_bank_pkg::id_t        i_out_id,
  input rsp_bank_pkg::payload_t   i_out_payload,
  input rsp_bank_pkg::cell_mask_t i_released_addr
);

  // At most one cell leaves per cycle
  a_released_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(i_released_addr))
    else $error("o_released_addr has more than one bit set");

  // The release pulse belongs to an output handshake
  a_released_on_fire: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (i_released_addr != '0) |-> (i_out_valid && i_out_ready))
    else $error("o_released_addr pulsed without an output handshake");

  // A stalled output keeps its response
  a_out_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (i_out_valid && !i_out_ready) |=> (i_out_valid && $stable(i_out_id) && $stable(i_out_payload)))
    else $error("output changed while back-pressured");

  a_in_ready_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    i_in_ready |-> i_in_valid)
    else $error("o_in_ready high without i_in_valid");

endmodule

// ==== bench/rsp_bank_tb.sv ====
`timescale 1ns/1ps

`include "rsp_bank_consts.svh"

module rsp_bank_tb;

  localparam int unsigned SEED = 82;
  localparam int CLK_PERIOD_NS = 10;
  localparam int NUM_CYCLES = 3000;
  localparam int DRAIN_TIMEOUT = 200;

  logic clk_i;
  logic rst_ni;
  logic i_rsv_valid;
  rsp_bank_pkg::id_t i_rsv_id;
  rsp_bank_pkg::cell_mask_t i_release_en;
  logic i_in_valid;
  rsp_bank_pkg::id_t i_in_id;
  rsp_bank_pkg::payload_t i_in_payload;
  logic i_out_ready;
  logic o_rsv_ready;
  rsp_bank_pkg::addr_t o_rsv_addr;
  rsp_bank_pkg::cell_mask_t o_released_addr;
  logic o_in_ready;
  logic o_out_valid;
  rsp_bank_pkg::id_t o_out_id;
  rsp_bank_pkg::payload_t o_out_payload;

  // Reference model with one ordered entry list per ID and the oldest entry at index 0
  rsp_bank_pkg::cell_mask_t m_occ;
  rsp_bank_pkg::addr_t m_addr [`RSP_BANK_NUM_IDS][`RSP_BANK_CAPA];
  logic m_filled [`RSP_BANK_NUM_IDS][`RSP_BANK_CAPA];
  rsp_bank_pkg::payload_t m_payload [`RSP_BANK_NUM_IDS][`RSP_BANK_CAPA];
  int m_count [`RSP_BANK_NUM_IDS];

  int unsigned rng_state;

  // Output seen stalled at the last sample must still be there at the next one
  logic held_valid;
  rsp_bank_pkg::id_t held_id;
  rsp_bank_pkg::payload_t held_payload;
  // Cells leaving at the coming edge have their enables dropped right after
  rsp_bank_pkg::cell_mask_t released_seen;

  rsp_bank uut (.*);

  bind rsp_bank rsp_bank_chk u_chk (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .i_in_valid      (i_in_valid),
    .i_out_ready     (i_out_ready),
    .i_in_ready      (o_in_ready),
    .i_out_valid     (o_out_valid),
    .i_out_id        (o_out_id),
    .i_out_payload   (o_out_payload),
    .i_released_addr (o_released_addr)
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic int unsigned next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    // Low LCG bits cycle quickly, so only the upper ones are used
    return rng_state >> 8;
  endfunction

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, actual, expected);
      $display("STATUS: FAIL");
      $fatal(1, "Simulation stopped at the first mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t ns: %s", $time, what);
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped after a timeout");
  endtask

  // Lowest cell the model holds as free or -1 when the bank is full
  function automatic int lowest_free_cell();
    int found;
    found = -1;
    for (int c = `RSP_BANK_CAPA - 1; c >= 0; c--) begin
      if (!m_occ[c]) begin
        found = c;
      end
    end
    return found;
  endfunction

  // Oldest reserved entry of an ID that still waits for its response
  function automatic int first_empty(input int id);
    int found;
    found = -1;
    for (int e = m_count[id] - 1; e >= 0; e--) begin
      if (!m_filled[id][e]) begin
        found = e;
      end
    end
    return found;
  endfunction

  function automatic int total_entries();
    int sum;
    sum = 0;
    for (int i = 0; i < `RSP_BANK_NUM_IDS; i++) begin
      sum += m_count[i];
    end
    return sum;
  endfunction

  ////////////////////////////////////////////////////////////
  // Per-cycle compare and model update
  ////////////////////////////////////////////////////////////

  // Runs at the falling edge and judges the handshakes of the coming rising edge
  task automatic check_cycle();
    int free_idx;
    int empty_idx;
    int oid;
    int rid;
    logic exp_in_ready;
    logic out_fire;
    free_idx = lowest_free_cell();
    oid = int'(o_out_id);
    rid = int'(i_rsv_id);
    out_fire = o_out_valid && i_out_ready;

    // A stalled output must not move
    if (held_valid) begin
      check_equal(32'(o_out_valid), 32'd1, "o_out_valid under back-pressure");
      check_equal(32'(o_out_id), 32'(held_id), "o_out_id under back-pressure");
      check_equal(32'(o_out_payload), 32'(held_payload), "o_out_payload under back-pressure");
    end
    held_valid = o_out_valid && !i_out_ready;
    held_id = o_out_id;
    held_payload = o_out_payload;

    // Reservation grant is the lowest free cell
    check_equal(32'(o_rsv_ready), 32'(free_idx >= 0), "o_rsv_ready");
    if (free_idx >= 0) begin
      check_equal(32'(o_rsv_addr), 32'(free_idx), "o_rsv_addr");
    end

    // Input accepted only if its ID has a reserved empty cell
    empty_idx = first_empty(int'(i_in_id));
    exp_in_ready = i_in_valid && (empty_idx >= 0);
    check_equal(32'(o_in_ready), 32'(exp_in_ready), "o_in_ready");

    released_seen = '0;
    if (out_fire) begin
      check_equal(32'((m_count[oid] != 0) && m_filled[oid][0]), 32'd1,
                  "oldest entry of o_out_id is filled");
      check_equal(32'(o_out_payload), 32'(m_payload[oid][0]), "o_out_payload");
      check_equal(32'(o_released_addr), 32'(rsp_bank_pkg::cell_mask_t'(1) << m_addr[oid][0]),
                  "o_released_addr");
      check_equal(32'(i_release_en[m_addr[oid][0]]), 32'd1, "release enable of released cell");
      released_seen = o_released_addr;
    end else begin
      check_equal(32'(o_released_addr), 32'd0, "o_released_addr without handshake");
    end

    // The model moves on only now since all expectations above came from the old state
    if (exp_in_ready) begin
      m_filled[int'(i_in_id)][empty_idx] = 1'b1;
      m_payload[int'(i_in_id)][empty_idx] = i_in_payload;
    end
    if (i_rsv_valid && (free_idx >= 0)) begin
      m_occ[free_idx] = 1'b1;
      m_addr[rid][m_count[rid]] = rsp_bank_pkg::addr_t'(free_idx);
      m_filled[rid][m_count[rid]] = 1'b0;
      m_count[rid]++;
    end
    if (out_fire) begin
      m_occ[m_addr[oid][0]] = 1'b0;
      for (int e = 0; e < `RSP_BANK_CAPA - 1; e++) begin
        m_addr[oid][e] = m_addr[oid][e + 1];
        m_filled[oid][e] = m_filled[oid][e + 1];
        m_payload[oid][e] = m_payload[oid][e + 1];
      end
      m_count[oid]--;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic drive_random();
    rsp_bank_pkg::cell_mask_t en;
    i_rsv_valid <= (next_rand() % 3) == 0;
    i_rsv_id <= rsp_bank_pkg::id_t'(next_rand());
    i_in_valid <= (next_rand() % 2) == 0;
    i_in_id <= rsp_bank_pkg::id_t'(next_rand());
    i_in_payload <= rsp_bank_pkg::payload_t'(next_rand());
    if ((next_rand() % 4) == 0) begin
      i_out_ready <= !i_out_ready;
    end
    // An enable stays up until its cell leaves while new ones appear at random
    en = i_release_en & ~released_seen;
    if ((next_rand() % 3) == 0) begin
      en[rsp_bank_pkg::addr_t'(next_rand())] = 1'b1;
    end
    i_release_en <= en;
  endtask

  // Fills every waiting reservation with all cells enabled and the lowest ID first
  task automatic drive_drain();
    int fill_id;
    fill_id = -1;
    for (int i = `RSP_BANK_NUM_IDS - 1; i >= 0; i--) begin
      if (first_empty(i) >= 0) begin
        fill_id = i;
      end
    end
    i_rsv_valid <= 1'b0;
    i_release_en <= '1;
    i_out_ready <= 1'b1;
    i_in_valid <= fill_id >= 0;
    i_in_id <= rsp_bank_pkg::id_t'(fill_id);
    i_in_payload <= rsp_bank_pkg::payload_t'(next_rand());
  endtask

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD_NS / 2) clk_i = ~clk_i;
  end

  initial begin
    int cycles;
    rng_state = SEED;
    m_occ = '0;
    m_count = '{default: 0};
    held_valid = 1'b0;
    held_id = '0;
    held_payload = '0;
    released_seen = '0;
    rst_ni = 1'b0;
    i_rsv_valid = 1'b0;
    i_rsv_id = '0;
    i_release_en = '0;
    i_in_valid = 1'b0;
    i_in_id = '0;
    i_in_payload = '0;
    i_out_ready = 1'b1;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Idle state right after reset
    @(negedge clk_i);
    check_equal(32'(o_out_valid), 32'd0, "o_out_valid after reset");
    check_cycle();

    for (int n = 0; n < NUM_CYCLES; n++) begin
      @(posedge clk_i);
      drive_random();
      @(negedge clk_i);
      check_cycle();
    end

    cycles = 0;
    while ((total_entries() != 0) || o_out_valid) begin
      if (cycles == DRAIN_TIMEOUT) begin
        report_timeout("the bank did not drain after stimulus stopped");
      end
      @(posedge clk_i);
      drive_drain();
      @(negedge clk_i);
      check_cycle();
      cycles++;
    end

    // Quiet cycles that offer an input on every ID while no list may accept one
    for (int i = 0; i < `RSP_BANK_NUM_IDS; i++) begin
      @(posedge clk_i);
      drive_drain();
      i_in_valid <= 1'b1;
      i_in_id <= rsp_bank_pkg::id_t'(i);
      @(negedge clk_i);
      check_cycle();
      check_equal(32'(o_out_valid), 32'd0, "o_out_valid after drain");
      check_equal(32'(o_in_ready), 32'd0, "o_in_ready after drain");
    end

    // With every cell free again the grants walk up through all addresses until the bank is full
    for (int c = 0; c <= `RSP_BANK_CAPA; c++) begin
      @(posedge clk_i);
      i_rsv_valid <= 1'b1;
      i_rsv_id <= rsp_bank_pkg::id_t'(c);
      i_in_valid <= 1'b0;
      @(negedge clk_i);
      check_cycle();
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+logic
logic/rsp_bank_pkg.sv
logic/rsp_bank_pop_if.sv
logic/rsp_bank_alloc.sv
logic/rsp_bank_lists.sv
logic/rsp_bank_payload_ram.sv
logic/rsp_bank_release.sv
logic/rsp_bank.sv
bench/rsp_bank_chk.sv
bench/rsp_bank_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= rsp_bank_tb
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
